// ==== sd_adma.f ====
+incdir+rtl
rtl/sd_adma_pkg.sv
rtl/word_fifo_if.sv
rtl/sys_ram.sv
rtl/adma_engine.sv
rtl/word_fifo.sv
rtl/dat_serializer.sv
rtl/sd_adma_top.sv
verif/tb_clkgen.sv
verif/sd_adma_assert.sv
verif/sd_adma_tb.sv

// ==== Makefile ====
# Verilator build for the SD ADMA testbench
VERILATOR ?= verilator
TOP       := sd_adma_tb
FILELIST  := sd_adma.f
OBJ_DIR   := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the binary is the pass or fail result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/sd_adma_tb.sv ====
// testbench for sd_adma_top with descriptor chains loaded through the host port
// expected nibbles come from a walk of the RAM image model
// inputs change 1 ns after the rising edge and outputs are sampled at the edge
`timescale 1ns/100ps
`default_nettype none

module sd_adma_tb;

   localparam int TOTAL_NIBBLES = 296;  // 88 + 88 + 32 + 0 + 88
   localparam int WATCHDOG_CYCLES = TOTAL_NIBBLES * 20 + 2000;

   logic CLK;
   logic rst_n;
   logic mem_wr;
   logic start;
   logic card_ready;
   logic dat_valid;
   logic busy;
   logic done;
   logic error;
   logic rand_ready;
   logic exp_done;
   logic exp_error;
   integer seed;
   int done_cnt;
   int err_cnt;
   sd_adma_pkg::addr_t mem_addr;
   sd_adma_pkg::addr_t base_addr;
   sd_adma_pkg::word_t mem_wdata;
   sd_adma_pkg::nibble_t dat;
   sd_adma_pkg::word_t model [256];
   sd_adma_pkg::nibble_t exp_q [$];

   tb_clkgen clkgen0 (.CLK(CLK), .rst_n(rst_n));

   sd_adma_top dut0 (
      .CLK(CLK), .rst_n(rst_n), .mem_wr(mem_wr), .mem_addr(mem_addr),
      .mem_wdata(mem_wdata), .start(start), .base_addr(base_addr),
      .card_ready(card_ready), .dat(dat), .dat_valid(dat_valid),
      .busy(busy), .done(done), .error(error)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // compare one DUT output bit with its expected level
   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("FAIL t=%0t %s expected %b received %b", $time, name, exp, got);
         fail_now("output level wrong");
      end
   endtask

   // descriptor slot in the model with word 3 left zero
   task automatic put_desc(input int byte_addr, input bit valid, input bit last,
                           input logic [1:0] act, input int len, input longint ptr);
      int w;
      w = byte_addr >> 2;
      model[w]     = {len[15:0], 10'h0, act, 2'b00, last, valid};
      model[w + 1] = ptr[31:0];
      model[w + 2] = ptr[63:32];
      model[w + 3] = '0;
   endtask

   task automatic load_image();
      for (int i = 0; i < 256; i++) begin
         mem_wr    = 1'b1;
         mem_addr  = i * 4;
         mem_wdata = model[i];
         @(posedge CLK);
         #1;
      end
      mem_wr = 1'b0;
   endtask

   // follow the descriptor rules from base and fill the expected stream
   task automatic walk(input longint base);
      longint a;
      longint ptr;
      sd_adma_pkg::word_t w0;
      int idx;
      a = base;
      for (int n = 0; n < 64; n++) begin
         idx = (a >> 2) & 255;
         w0  = model[idx];
         ptr = {model[idx + 2], model[idx + 1]};
         if (!w0[0]) begin
            exp_error = 1'b1;
            break;
         end
         if (w0[5:4] == 2'b01) begin
            for (int i = 0; i < w0[31:16]; i++)
               for (int k = 7; k >= 0; k--)
                  exp_q.push_back(model[((ptr >> 2) + i) & 255][k*4 +: 4]);
            a = a + 16;
         end else if (w0[5:4] == 2'b11) begin
            a = ptr;  // link
         end else begin
            a = a + 16;  // nop and reserved
         end
         if (w0[1]) begin
            exp_done = 1'b1;
            break;
         end
      end
   endtask

   task automatic run_table(input longint base, input bit rnd, input bit restart);
      int guard;
      done_cnt = 0;
      err_cnt = 0;
      exp_done = 1'b0;
      exp_error = 1'b0;
      load_image();
      walk(base);
      rand_ready = rnd;
      start = 1'b1;
      base_addr = base;
      @(posedge CLK);
      #1 start = 1'b0;
      if (restart) begin
         repeat (3) @(posedge CLK);
         #1;
         check_bit("busy", busy, 1'b1);
         start = 1'b1;
         base_addr = 64'h80;  // must be ignored
         @(posedge CLK);
         #1 start = 1'b0;
      end
      while (busy) @(posedge CLK);
      guard = 0;
      while (exp_q.size() != 0 && guard < 2000) begin
         @(posedge CLK);
         guard++;
      end
      if (exp_q.size() != 0) fail_now("expected nibbles never arrived");
      repeat (20) @(posedge CLK);  // catch stray nibbles
      #1;
      if (done_cnt != (exp_done ? 1 : 0)) fail_now("wrong number of done pulses");
      if (err_cnt != (exp_error ? 1 : 0)) fail_now("wrong number of error pulses");
   endtask

   // nibble scoreboard and pulse counters
   always @(posedge CLK) begin
      sd_adma_pkg::nibble_t e;
      if (rst_n && dat_valid) begin
         if (exp_q.size() == 0) fail_now("nibble received with none expected");
         e = exp_q.pop_front();
         assert (dat == e) else begin
            $display("FAIL t=%0t dat expected %h received %h", $time, e, dat);
            fail_now("nibble mismatch");
         end
      end
      if (rst_n && done) begin
         if (!exp_done) fail_now("unexpected done pulse");
         done_cnt++;
      end
      if (rst_n && error) begin
         if (!exp_error) fail_now("unexpected error pulse");
         err_cnt++;
      end
   end

   always @(posedge CLK) begin
      #1 card_ready <= rand_ready ? (($random(seed) & 3) == 0) : 1'b1;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge CLK);
      fail_now("watchdog timeout, run did not finish");
   end

   initial begin
      seed = 32'h007ce09a;
      mem_wr = 1'b0;
      mem_addr = '0;
      mem_wdata = '0;
      start = 1'b0;
      base_addr = '0;
      card_ready = 1'b0;
      rand_ready = 1'b0;
      exp_done = 1'b0;
      exp_error = 1'b0;
      for (int i = 0; i < 256; i++) model[i] = (i < 128) ? '0 : $random(seed);
      put_desc(16'h000, 1, 0, 2'b01, 5, 64'h200);    // tran
      put_desc(16'h010, 1, 0, 2'b11, 0, 64'h40);     // link
      put_desc(16'h040, 1, 1, 2'b01, 6, 64'h280);    // tran with end
      put_desc(16'h080, 1, 0, 2'b00, 3, 64'h200);    // nop
      put_desc(16'h090, 1, 0, 2'b10, 3, 64'h200);    // reserved
      put_desc(16'h0a0, 1, 0, 2'b01, 0, 64'h200);    // empty tran
      put_desc(16'h0b0, 1, 1, 2'b01, 4, 64'h300);
      put_desc(16'h0c0, 1, 0, 2'b11, 0, 64'he0);
      put_desc(16'h0e0, 0, 0, 2'b01, 3, 64'h200);    // valid clear
      @(posedge rst_n);
      @(posedge CLK);
      #1;
      check_bit("busy", busy, 1'b0);
      check_bit("done", done, 1'b0);
      check_bit("error", error, 1'b0);
      check_bit("dat_valid", dat_valid, 1'b0);
      run_table(64'h00, 1'b0, 1'b0);
      run_table(64'h00, 1'b1, 1'b0);
      run_table(64'h80, 1'b0, 1'b0);
      run_table(64'hc0, 1'b0, 1'b0);
      run_table(64'h00, 1'b1, 1'b1);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/sd_adma_assert.sv ====
// protocol checks on the ADMA datapath, bound into sd_adma_top
// FIFO handshake rules, DAT pacing, done and error pulse shape
`timescale 1ns/100ps
`default_nettype none

module sd_adma_assert (
   input wire CLK,
   input wire rst_n,
   input wire push,
   input wire full,
   input wire pop,
   input wire empty,
   input wire card_ready,
   input wire dat_valid,
   input wire busy,
   input wire done,
   input wire error
);

   a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n) !(push && full))
      else $error("push issued while FIFO full");

   a_no_pop_empty: assert property (@(posedge CLK) disable iff (!rst_n) !(pop && empty))
      else $error("pop issued while FIFO empty");

   a_dat_paced: assert property (@(posedge CLK) disable iff (!rst_n) dat_valid |-> card_ready)
      else $error("dat_valid without card_ready");

   a_done_err_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(done && error))
      else $error("done and error high together");

   // both are one-cycle pulses
   a_done_pulse: assert property (@(posedge CLK) disable iff (!rst_n) done |=> !done)
      else $error("done longer than one cycle");

   a_err_pulse: assert property (@(posedge CLK) disable iff (!rst_n) error |=> !error)
      else $error("error longer than one cycle");

   a_busy_reset: assert property (@(posedge CLK) $rose(rst_n) |-> !busy)
      else $error("busy high right after reset");

endmodule

bind sd_adma_top sd_adma_assert u_assert (
   .CLK        (CLK),
   .rst_n      (rst_n),
   .push       (fifo_bus.push),
   .full       (fifo_bus.full),
   .pop        (fifo_bus.pop),
   .empty      (fifo_bus.empty),
   .card_ready (card_ready),
   .dat_valid  (dat_valid),
   .busy       (busy),
   .done       (done),
   .error      (error)
);

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// clock and reset source for the testbench
// 20 ns period, rst_n low for the first 4 rising edges
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
   output logic CLK,
   output logic rst_n
);

   initial begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   initial begin
      rst_n = 1'b0;
      repeat (4) @(posedge CLK);
      #1 rst_n = 1'b1;  // released just after the edge
   end

endmodule

`default_nettype wire

// ==== rtl/sd_adma_top.sv ====
// system-memory side of the SD host ADMA, host-to-card data only
// host port writes the RAM, use it only while busy is low
// start with base_addr is taken only when busy is low
// no command line, CRC or block framing on dat
`timescale 1ns/100ps
`default_nettype none

module sd_adma_top (
   input  wire                      CLK,
   input  wire                      rst_n,
   input  wire                      mem_wr,
   input  wire sd_adma_pkg::addr_t  mem_addr,
   input  wire sd_adma_pkg::word_t  mem_wdata,
   input  wire                      start,
   input  wire sd_adma_pkg::addr_t  base_addr,
   input  wire                      card_ready,
   output sd_adma_pkg::nibble_t     dat,
   output logic                     dat_valid,
   output logic                     busy,
   output logic                     done,
   output logic                     error
);

   logic               ram_rd_en;
   sd_adma_pkg::addr_t ram_rd_addr;
   sd_adma_pkg::word_t ram_rd_data;

   word_fifo_if fifo_bus ();

   sys_ram u_ram (
      .CLK     (CLK),
      .rst_n   (rst_n),
      .wr      (mem_wr),
      .wr_addr (mem_addr),
      .wr_data (mem_wdata),
      .rd_en   (ram_rd_en),
      .rd_addr (ram_rd_addr),
      .rd_data (ram_rd_data)
   );

   adma_engine u_engine (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .start     (start),
      .base_addr (base_addr),
      .rd_en     (ram_rd_en),
      .rd_addr   (ram_rd_addr),
      .rd_data   (ram_rd_data),
      .fifo      (fifo_bus),
      .busy      (busy),
      .done      (done),
      .error     (error)
   );

   word_fifo u_fifo (
      .CLK   (CLK),
      .rst_n (rst_n),
      .q     (fifo_bus)
   );

   dat_serializer u_ser (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .q          (fifo_bus),
      .card_ready (card_ready),
      .dat        (dat),
      .dat_valid  (dat_valid)
   );

endmodule

`default_nettype wire

// ==== rtl/dat_serializer.sv ====
// word to nibble serializer for the 4-bit DAT bus, high nibble first
// one nibble per card_ready cycle, dat_valid follows card_ready
// reload takes one idle cycle, so 8 nibbles per 9 ready cycles at best
`timescale 1ns/100ps
`default_nettype none

module dat_serializer (
   input  wire                  CLK,
   input  wire                  rst_n,
   word_fifo_if.cons            q,
   input  wire                  card_ready,
   output sd_adma_pkg::nibble_t dat,
   output logic                 dat_valid
);

   sd_adma_pkg::word_t sreg;    // word being shifted out
   logic [2:0]         cnt;     // nibbles already sent
   logic               loaded;

   assign q.pop     = !loaded && !q.empty;  // fetch only when idle
   assign dat       = sreg[31:28];
   assign dat_valid = loaded && card_ready;

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         loaded <= 1'b0;
         cnt    <= '0;
      end else if (q.pop) begin
         loaded <= 1'b1;
         cnt    <= '0;
      end else if (dat_valid) begin
         cnt <= cnt + 3'd1;
         if (cnt == 3'd7) loaded <= 1'b0;  // eighth nibble out
      end
   end

   always_ff @(posedge CLK) begin
      if (q.pop) begin
         sreg <= q.rdata;
      end else if (dat_valid) begin
         sreg <= {sreg[27:0], 4'h0};
      end
   end

endmodule

`default_nettype wire

// ==== rtl/word_fifo.sv ====
// synchronous word FIFO, depth from the config header (power of two)
// pointers carry a wrap bit, full and empty come from the compare
// a push while full or a pop while empty is dropped
`timescale 1ns/100ps
`default_nettype none
`include "sd_adma_config.svh"

module word_fifo (
   input wire        CLK,
   input wire        rst_n,
   word_fifo_if.buf_side q
);

   localparam int DEPTH = `SD_ADMA_FIFO_DEPTH;
   localparam int AW    = $clog2(DEPTH);

   sd_adma_pkg::word_t mem [DEPTH];

   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   assign q.empty = (wr_ptr == rd_ptr);
   assign q.full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                    (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);  // wrapped once
   assign q.rdata = mem[rd_ptr[AW-1:0]];                 // head entry

   assign do_push = q.push && !q.full;
   assign do_pop  = q.pop && !q.empty;

   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr[AW-1:0]] <= q.wdata;
      end
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/adma_engine.sv ====
// ADMA descriptor walker, fetches three words per slot then acts on it
// tran words go to the FIFO, one read in flight at most
// a stalled word waits in the RAM read register until full drops
// start is ignored while busy; the int attribute bit is not used
`timescale 1ns/100ps
`default_nettype none
`include "sd_adma_config.svh"

module adma_engine (
   input  wire                      CLK,
   input  wire                      rst_n,
   input  wire                      start,
   input  wire sd_adma_pkg::addr_t  base_addr,
   output logic                     rd_en,
   output sd_adma_pkg::addr_t       rd_addr,
   input  wire sd_adma_pkg::word_t  rd_data,
   word_fifo_if.prod                fifo,
   output logic                     busy,
   output logic                     done,
   output logic                     error
);

   localparam sd_adma_pkg::addr_t STRIDE = `SD_ADMA_DESC_BYTES;

   sd_adma_pkg::eng_state_e state;
   sd_adma_pkg::addr_t      desc_addr;  // current slot
   sd_adma_pkg::addr_t      data_ptr;   // next tran word
   sd_adma_pkg::addr_t      full_addr;
   sd_adma_pkg::word_t      addr_lo;    // descriptor word 1
   sd_adma_pkg::len_t       len;
   sd_adma_pkg::len_t       remaining;  // reads still to issue
   sd_adma_pkg::act_e       act;
   logic                    attr_valid;
   logic                    attr_end;
   logic                    pend;       // read issued last cycle, not yet pushed
   logic                    issue;

   assign full_addr  = {rd_data, addr_lo};  // word 2 is on rd_data in DECODE
   assign issue      = (state == sd_adma_pkg::DATA) && !fifo.full;
   assign fifo.push  = pend && !fifo.full;
   assign fifo.wdata = rd_data;
   assign busy       = (state != sd_adma_pkg::IDLE);

   always_comb begin
      rd_en   = 1'b0;
      rd_addr = data_ptr;
      case (state)
         sd_adma_pkg::FETCH0: begin
            rd_en   = 1'b1;
            rd_addr = desc_addr;
         end
         sd_adma_pkg::FETCH1: begin
            rd_en   = 1'b1;
            rd_addr = desc_addr + 64'd4;
         end
         sd_adma_pkg::FETCH2: begin
            rd_en   = 1'b1;
            rd_addr = desc_addr + 64'd8;
         end
         sd_adma_pkg::DATA: rd_en = issue;
         default: ;
      endcase
   end

   // control
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         state     <= sd_adma_pkg::IDLE;
         pend      <= 1'b0;
         remaining <= '0;
         done      <= 1'b0;
         error     <= 1'b0;
      end else begin
         done  <= 1'b0;
         error <= 1'b0;
         pend  <= issue || (pend && fifo.full);  // hold while stalled
         case (state)
            sd_adma_pkg::IDLE:   if (start) state <= sd_adma_pkg::FETCH0;
            sd_adma_pkg::FETCH0: state <= sd_adma_pkg::FETCH1;
            sd_adma_pkg::FETCH1: state <= sd_adma_pkg::FETCH2;
            sd_adma_pkg::FETCH2: state <= sd_adma_pkg::DECODE;
            sd_adma_pkg::DECODE: begin
               remaining <= len;
               if (!attr_valid) begin
                  error <= 1'b1;
                  state <= sd_adma_pkg::IDLE;
               end else if (act == sd_adma_pkg::ACT_TRAN && len != '0) begin
                  state <= sd_adma_pkg::DATA;
               end else if (attr_end) begin
                  done  <= 1'b1;
                  state <= sd_adma_pkg::IDLE;
               end else begin
                  state <= sd_adma_pkg::FETCH0;
               end
            end
            sd_adma_pkg::DATA: begin
               if (issue) begin
                  remaining <= remaining - 16'd1;
                  if (remaining == 16'd1) state <= sd_adma_pkg::DRAIN;
               end
            end
            sd_adma_pkg::DRAIN: begin
               if (!fifo.full) begin  // last word pushed now
                  if (attr_end) begin
                     done  <= 1'b1;
                     state <= sd_adma_pkg::IDLE;
                  end else begin
                     state <= sd_adma_pkg::FETCH0;
                  end
               end
            end
            default: state <= sd_adma_pkg::IDLE;
         endcase
      end
   end

   // descriptor fields and pointers
   always_ff @(posedge CLK) begin
      case (state)
         sd_adma_pkg::IDLE: if (start) desc_addr <= base_addr;
         sd_adma_pkg::FETCH1: begin
            attr_valid <= rd_data[0];
            attr_end   <= rd_data[1];
            act        <= sd_adma_pkg::act_e'(rd_data[5:4]);
            len        <= rd_data[31:16];
         end
         sd_adma_pkg::FETCH2: addr_lo <= rd_data;
         sd_adma_pkg::DECODE: begin
            data_ptr <= full_addr;
            if (act == sd_adma_pkg::ACT_LINK) begin
               desc_addr <= full_addr;
            end else if (act != sd_adma_pkg::ACT_TRAN || len == '0) begin
               desc_addr <= desc_addr + STRIDE;  // nop, reserved, empty tran
            end
         end
         sd_adma_pkg::DATA: if (issue) data_ptr <= data_ptr + 64'd4;
         sd_adma_pkg::DRAIN: if (!fifo.full) desc_addr <= desc_addr + STRIDE;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/sys_ram.sv ====
// system RAM model, host write port plus one registered read port
// word index is address bits [2 and up], higher bits are ignored
// contents are undefined until the host port writes them
`timescale 1ns/100ps
`default_nettype none
`include "sd_adma_config.svh"

module sys_ram (
   input  wire                       CLK,
   input  wire                       rst_n,
   input  wire                       wr,
   input  wire sd_adma_pkg::addr_t   wr_addr,
   input  wire sd_adma_pkg::word_t   wr_data,
   input  wire                       rd_en,
   input  wire sd_adma_pkg::addr_t   rd_addr,
   output sd_adma_pkg::word_t        rd_data
);

   localparam int AW = $clog2(`SD_ADMA_RAM_WORDS);

   sd_adma_pkg::word_t mem [`SD_ADMA_RAM_WORDS];

   logic [AW-1:0] wr_idx;
   logic [AW-1:0] rd_idx;

   assign wr_idx = wr_addr[AW+1:2];  // byte address to word index
   assign rd_idx = rd_addr[AW+1:2];

   // host writes land at the edge
   always_ff @(posedge CLK) begin
      if (wr) begin
         mem[wr_idx] <= wr_data;
      end
   end

   // read data is held while rd_en is low, the engine relies on it
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         rd_data <= '0;
      end else if (rd_en) begin
         rd_data <= mem[rd_idx];
      end
   end

endmodule

`default_nettype wire

// ==== rtl/word_fifo_if.sv ====
// push/pop bundle between the ADMA engine, the word FIFO and the serializer
// no push while full, no pop while empty; rdata is the head when empty is low
`timescale 1ns/100ps
`default_nettype none

interface word_fifo_if;

   logic               push;   // engine side
   sd_adma_pkg::word_t wdata;
   logic               full;
   logic               pop;    // serializer side
   sd_adma_pkg::word_t rdata;
   logic               empty;

   modport prod (output push, output wdata, input full);

   modport buf_side (input push, input wdata, input pop,
                     output full, output rdata, output empty);

   modport cons (output pop, input rdata, input empty);

endinterface

`default_nettype wire

// ==== rtl/sd_adma_pkg.sv ====
// shared types for the ADMA descriptor engine and its datapath
// addresses are byte addresses, the RAM only decodes the word index
`default_nettype none

package sd_adma_pkg;

   typedef logic [31:0] word_t;    // system RAM data word
   typedef logic [63:0] addr_t;    // 64-bit byte address
   typedef logic [15:0] len_t;     // word count from descriptor word 0
   typedef logic [3:0]  nibble_t;  // DAT[3:0]

   // descriptor attribute bits [5:4]
   typedef enum logic [1:0] {
      ACT_NOP  = 2'b00,
      ACT_TRAN = 2'b01,
      ACT_RSVD = 2'b10,  // behaves as nop
      ACT_LINK = 2'b11
   } act_e;

   typedef enum logic [2:0] {
      IDLE,
      FETCH0,  // read word 0
      FETCH1,  // word 0 back, read word 1
      FETCH2,  // word 1 back, read word 2
      DECODE,  // word 2 back, act on the descriptor
      DATA,    // tran reads
      DRAIN    // last tran word still in flight
   } eng_state_e;

endpackage

`default_nettype wire

// ==== rtl/sd_adma_config.svh ====
// build-time sizes for the ADMA datapath
// FIFO depth must stay a power of two, the pointer compare relies on it
// RAM depth sets how many address bits the RAM decodes
`ifndef SD_ADMA_CONFIG_SVH
`define SD_ADMA_CONFIG_SVH

// system RAM size in 32-bit words
`define SD_ADMA_RAM_WORDS 256

// word FIFO entries between engine and DAT serializer
`define SD_ADMA_FIFO_DEPTH 8

// one descriptor slot, four words
`define SD_ADMA_DESC_BYTES 16

`endif
